// File: hdl/index_counter.sv
`default_nettype none

module index_counter (
  input  wire logic i_clk,
  input  wire logic i_reset,
  index_if.counter  cnt
);

  linear_pkg::idx_t index_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      index_q <= '0;
    end else if (cnt.clear) begin
      index_q <= '0;
    end else if (cnt.step) begin
      // Wrap at the end of each phase
      if (cnt.last) begin
        index_q <= '0;
      end else begin
        index_q <= index_q + linear_pkg::idx_t'(1);
      end
    end
  end

  assign cnt.index = index_q;
  assign cnt.last  = (index_q == cnt.limit - linear_pkg::idx_t'(1));

  // The controller changes limit only at phase boundaries
  a_index_in_range : assert property (
    @(posedge i_clk) disable iff (i_reset)
    cnt.step |-> (cnt.index < cnt.limit)
  );

  // Nothing moves the counter before the first load
  a_no_step_idle : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (cnt.state == linear_pkg::ST_IDLE) |-> !cnt.step
  );

endmodule

`default_nettype wire

// File: hdl/index_if.sv
`default_nettype none

interface index_if;

  logic              clear;
  logic              step;
  linear_pkg::idx_t  limit;
  linear_pkg::idx_t  index;
  logic              last;

  // Controller phase, visible to the counter for its checks
  linear_pkg::state_t state;

  modport controller (
    output clear, step, limit, state,
    input  index, last
  );

  modport counter (
    input  clear, step, limit, state,
    output index, last
  );

endinterface

`default_nettype wire

// File: hdl/layer_controller.sv
`default_nettype none

module layer_controller (
  input  wire logic i_clk,
  input  wire logic i_reset,
  input  wire logic i_load,
  input  wire logic i_w_valid,
  output logic      o_w_ready,
  output logic      o_we,
  input  wire logic i_x_valid,
  output logic      o_x_ready,
  output logic      o_accumulate,
  output logic      o_first,
  output logic      o_finish,
  input  wire logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] i_result,
  output logic      o_slice_load,
  output logic [linear_pkg::DATA_WIDTH-1:0] o_slice_data,
  output logic      o_slice_last,
  input  wire logic i_slice_empty,
  input  wire logic i_y_handshake,
  index_if.controller cnt
);

  linear_pkg::state_t state_q;
  linear_pkg::state_t state_d;
  logic finish_q;
  logic reload;
  logic w_fire;
  logic x_fire;
  logic y_fire;

  // A reload is only taken between vectors
  assign reload = i_load && ((state_q == linear_pkg::ST_IDLE) ||
                  ((state_q == linear_pkg::ST_ACCUM) && (cnt.index == '0)));

  assign o_w_ready = (state_q == linear_pkg::ST_LOAD);
  assign o_x_ready = (state_q == linear_pkg::ST_ACCUM) && !reload;
  assign w_fire    = o_w_ready && i_w_valid;
  assign x_fire    = o_x_ready && i_x_valid;
  assign y_fire    = (state_q == linear_pkg::ST_EMIT) && i_y_handshake;

  assign o_we         = w_fire;
  assign o_accumulate = x_fire;
  assign o_first      = (cnt.index == '0);
  assign o_finish     = finish_q;

  // Results go out once finish has settled and the slice has room
  assign o_slice_load = (state_q == linear_pkg::ST_EMIT) && !finish_q && i_slice_empty;
  assign o_slice_data = i_result[cnt.index[1:0]];
  assign o_slice_last = cnt.last;

  assign cnt.clear = reload;
  assign cnt.step  = w_fire || x_fire || y_fire;
  assign cnt.state = state_q;

  always_comb begin
    case (state_q)
      linear_pkg::ST_LOAD: cnt.limit = linear_pkg::idx_t'(linear_pkg::LOAD_BEATS);
      linear_pkg::ST_EMIT: cnt.limit = linear_pkg::idx_t'(linear_pkg::OUT_FEATURES);
      default:             cnt.limit = linear_pkg::idx_t'(linear_pkg::IN_FEATURES);
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      linear_pkg::ST_IDLE: begin
        if (reload) state_d = linear_pkg::ST_LOAD;
      end
      linear_pkg::ST_LOAD: begin
        if (w_fire && cnt.last) state_d = linear_pkg::ST_ACCUM;
      end
      linear_pkg::ST_ACCUM: begin
        if (reload) begin
          state_d = linear_pkg::ST_LOAD;
        end else if (x_fire && cnt.last) begin
          state_d = linear_pkg::ST_EMIT;
        end
      end
      linear_pkg::ST_EMIT: begin
        // Counter tracks accepted results here
        if (y_fire && cnt.last) state_d = linear_pkg::ST_ACCUM;
      end
      default: state_d = linear_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q  <= linear_pkg::ST_IDLE;
      finish_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      finish_q <= x_fire && cnt.last;
    end
  end

  a_no_x_in_load : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (state_q == linear_pkg::ST_LOAD) |-> !o_x_ready
  );

  a_w_only_in_load : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (state_q != linear_pkg::ST_LOAD) |-> !o_w_ready
  );

endmodule

`default_nettype wire

// File: hdl/linear_layer.sv
`default_nettype none

module linear_layer (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset,
  input  wire logic                              i_load,
  input  wire logic [linear_pkg::DATA_WIDTH-1:0] i_w_data,
  input  wire logic                              i_w_valid,
  output logic                                   o_w_ready,
  input  wire logic [linear_pkg::DATA_WIDTH-1:0] i_x_data,
  input  wire logic                              i_x_valid,
  output logic                                   o_x_ready,
  output logic [linear_pkg::DATA_WIDTH-1:0]      o_y_data,
  output logic                                   o_y_valid,
  output logic                                   o_y_last,
  input  wire logic                              i_y_ready
);

  logic we;
  logic accumulate;
  logic first;
  logic finish;
  logic slice_load;
  logic slice_last;
  logic slice_empty;
  logic y_handshake;
  logic [linear_pkg::DATA_WIDTH-1:0] slice_data;
  logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] weights;
  logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] bias;
  logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] result;

  index_if idx ();

  assign y_handshake = o_y_valid & i_y_ready;

  index_counter u_index_counter (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .cnt     (idx.counter)
  );

  // Counter doubles as load address and input column
  weight_store u_weight_store (
    .i_clk     (i_clk),
    .i_w_data  (i_w_data),
    .i_we      (we),
    .i_addr    (idx.index),
    .i_col     (idx.index[1:0]),
    .o_weights (weights),
    .o_bias    (bias)
  );

  mac_array u_mac_array (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_x_data     (i_x_data),
    .i_weights    (weights),
    .i_bias       (bias),
    .i_accumulate (accumulate),
    .i_first      (first),
    .i_finish     (finish),
    .o_result     (result)
  );

  output_slice u_output_slice (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_load    (slice_load),
    .i_data    (slice_data),
    .i_last    (slice_last),
    .o_empty   (slice_empty),
    .o_y_data  (o_y_data),
    .o_y_valid (o_y_valid),
    .o_y_last  (o_y_last),
    .i_y_ready (i_y_ready)
  );

  layer_controller u_layer_controller (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_load        (i_load),
    .i_w_valid     (i_w_valid),
    .o_w_ready     (o_w_ready),
    .o_we          (we),
    .i_x_valid     (i_x_valid),
    .o_x_ready     (o_x_ready),
    .o_accumulate  (accumulate),
    .o_first       (first),
    .o_finish      (finish),
    .i_result      (result),
    .o_slice_load  (slice_load),
    .o_slice_data  (slice_data),
    .o_slice_last  (slice_last),
    .i_slice_empty (slice_empty),
    .i_y_handshake (y_handshake),
    .cnt           (idx.controller)
  );

endmodule

`default_nettype wire

// File: hdl/linear_pkg.sv
`default_nettype none

package linear_pkg;

  // Layer shape
  localparam int IN_FEATURES  = 4;
  localparam int OUT_FEATURES = 4;

  // Fixed-point format shared by data, weights, bias and output
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_WIDTH = 3;

  // Four 32-bit products plus the scaled bias fit with headroom
  localparam int ACC_WIDTH = 36;

  // Row-major weights first, then one bias per output
  localparam int LOAD_BEATS = OUT_FEATURES * IN_FEATURES + OUT_FEATURES;

  localparam int IDX_WIDTH = 5;

  typedef logic [IDX_WIDTH-1:0] idx_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_ACCUM,
    ST_EMIT
  } state_t;

endpackage

`default_nettype wire

// File: hdl/mac_array.sv
`default_nettype none

module mac_array (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset,
  input  wire logic [linear_pkg::DATA_WIDTH-1:0] i_x_data,
  input  wire logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] i_weights,
  input  wire logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] i_bias,
  input  wire logic                              i_accumulate,
  input  wire logic                              i_first,
  input  wire logic                              i_finish,
  output logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] o_result
);

  logic signed [linear_pkg::ACC_WIDTH-1:0]    acc_q    [linear_pkg::OUT_FEATURES];
  logic signed [2*linear_pkg::DATA_WIDTH-1:0] product  [linear_pkg::OUT_FEATURES];
  logic signed [linear_pkg::ACC_WIDTH-1:0]    bias_ext [linear_pkg::OUT_FEATURES];
  logic signed [linear_pkg::ACC_WIDTH-1:0]    biased   [linear_pkg::OUT_FEATURES];
  logic signed [linear_pkg::ACC_WIDTH-1:0]    shifted  [linear_pkg::OUT_FEATURES];
  logic [linear_pkg::DATA_WIDTH-1:0]          sat      [linear_pkg::OUT_FEATURES];
  logic [linear_pkg::ACC_WIDTH-linear_pkg::DATA_WIDTH:0] upper [linear_pkg::OUT_FEATURES];

  always_comb begin
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      product[r]  = $signed(i_x_data) * $signed(i_weights[r]);
      // Bias moves up to the product's fractional scale
      bias_ext[r] = $signed(i_bias[r]);
      biased[r]   = acc_q[r] + (bias_ext[r] <<< linear_pkg::FRAC_WIDTH);
      shifted[r]  = biased[r] >>> linear_pkg::FRAC_WIDTH;
      // In range when every bit above the output sign matches it
      upper[r]    = shifted[r][linear_pkg::ACC_WIDTH-1:linear_pkg::DATA_WIDTH-1];
      if ((&upper[r]) || !(|upper[r])) begin
        sat[r] = shifted[r][linear_pkg::DATA_WIDTH-1:0];
      end else begin
        sat[r] = {shifted[r][linear_pkg::ACC_WIDTH-1],
                  {(linear_pkg::DATA_WIDTH-1){~shifted[r][linear_pkg::ACC_WIDTH-1]}}};
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      if (i_reset) begin
        acc_q[r] <= '0;
      end else if (i_accumulate) begin
        // First element of a vector starts a fresh sum
        if (i_first) begin
          acc_q[r] <= product[r];
        end else begin
          acc_q[r] <= acc_q[r] + product[r];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_finish) begin
      for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
        o_result[r] <= sat[r];
      end
    end
  end

  // Finish only comes after the last element has been summed
  a_finish_alone : assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_finish |-> !i_accumulate
  );

endmodule

`default_nettype wire

// File: hdl/output_slice.sv
`default_nettype none

module output_slice (
  input  wire logic                              i_clk,
  input  wire logic                              i_reset,
  input  wire logic                              i_load,
  input  wire logic [linear_pkg::DATA_WIDTH-1:0] i_data,
  input  wire logic                              i_last,
  output logic                                   o_empty,
  output logic [linear_pkg::DATA_WIDTH-1:0]      o_y_data,
  output logic                                   o_y_valid,
  output logic                                   o_y_last,
  input  wire logic                              i_y_ready
);

  logic full_q;
  logic last_q;
  logic [linear_pkg::DATA_WIDTH-1:0] data_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      full_q <= 1'b0;
      last_q <= 1'b0;
    end else if (i_load) begin
      full_q <= 1'b1;
      last_q <= i_last;
    end else if (full_q && i_y_ready) begin
      // Handshake frees the entry
      full_q <= 1'b0;
      last_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      data_q <= i_data;
    end
  end

  assign o_empty   = ~full_q;
  assign o_y_valid = full_q;
  assign o_y_data  = data_q;
  assign o_y_last  = last_q;

  // Held data must not change under back-pressure
  a_hold_data : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (o_y_valid && !i_y_ready) |=> (o_y_valid && $stable(o_y_data) && $stable(o_y_last))
  );

  a_load_empty : assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_load |-> o_empty
  );

endmodule

`default_nettype wire

// File: hdl/weight_store.sv
`default_nettype none

module weight_store (
  input  wire logic                         i_clk,
  input  wire logic [linear_pkg::DATA_WIDTH-1:0] i_w_data,
  input  wire logic                         i_we,
  input  wire logic [linear_pkg::IDX_WIDTH-1:0]  i_addr,
  input  wire logic [1:0]                   i_col,
  output logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] o_weights,
  output logic [linear_pkg::OUT_FEATURES-1:0][linear_pkg::DATA_WIDTH-1:0] o_bias
);

  // Words 0..15 hold W[row][col] at row*4+col, words 16..19 the bias
  logic [linear_pkg::DATA_WIDTH-1:0] mem [linear_pkg::LOAD_BEATS];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_w_data;
    end
  end

  // One column of W feeds all four accumulators
  always_comb begin
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      o_weights[r] = mem[r * linear_pkg::IN_FEATURES + int'(i_col)];
    end
  end

  always_comb begin
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      o_bias[r] = mem[linear_pkg::OUT_FEATURES * linear_pkg::IN_FEATURES + r];
    end
  end

  // Load beats never run past the bias words
  a_addr_in_range : assert property (
    @(posedge i_clk)
    i_we |-> (int'(i_addr) < linear_pkg::LOAD_BEATS)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench together with the RTL
verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_linear_layer -o sim_linear_layer

./obj_dir/sim_linear_layer > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
  echo "Simulation ended without a pass result"
  exit 1
fi

exit 0

// File: sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic o_clk
);

  localparam int HALF_PERIOD = 5;

  // Free-running clock with a period of 10
  initial begin
    o_clk = 1'b0;
    forever begin
      #HALF_PERIOD;
      o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_linear_layer.sv
`default_nettype none

module tb_linear_layer;

  localparam int CLK_PERIOD     = 10;
  localparam int NUM_VECTORS    = 29;
  localparam int TIMEOUT_CYCLES = 200 * NUM_VECTORS + 2000;
  localparam logic [31:0] SEED  = 32'h78e6_34cb;

  logic clk;
  logic reset;
  logic load;
  logic [linear_pkg::DATA_WIDTH-1:0] w_data;
  logic w_valid;
  logic w_ready;
  logic [linear_pkg::DATA_WIDTH-1:0] x_data;
  logic x_valid;
  logic x_ready;
  logic [linear_pkg::DATA_WIDTH-1:0] y_data;
  logic y_valid;
  logic y_last;
  logic y_ready;

  // Reference copy of the loaded weights and the current input vector
  logic signed [15:0] w_mat [linear_pkg::OUT_FEATURES][linear_pkg::IN_FEATURES];
  logic signed [15:0] b_vec [linear_pkg::OUT_FEATURES];
  logic signed [15:0] cur_x [linear_pkg::IN_FEATURES];
  logic [15:0] exp_q [$];

  string test_name;
  logic [31:0] rng_stim;
  logic [31:0] rng_ready;
  logic random_ready;
  logic loaded;
  logic loading;
  logic [1:0] x_elem;
  logic [1:0] out_idx;
  logic last_x_d1;
  logic last_x_d2;

  tb_clock_gen u_clock_gen (
    .o_clk (clk)
  );

  linear_layer UUT (
    .i_clk     (clk),
    .i_reset   (reset),
    .i_load    (load),
    .i_w_data  (w_data),
    .i_w_valid (w_valid),
    .o_w_ready (w_ready),
    .i_x_data  (x_data),
    .i_x_valid (x_valid),
    .o_x_ready (x_ready),
    .o_y_data  (y_data),
    .o_y_valid (y_valid),
    .o_y_last  (y_last),
    .i_y_ready (y_ready)
  );

  task automatic stop_on_error();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic report_mismatch(input string what, input int expected, input int actual);
    $display("[FAIL] test %s, %s: expected %0d, actual %0d", test_name, what, expected, actual);
    stop_on_error();
  endtask

  task automatic report_problem(input string what);
    $display("Error in test %s: %s", test_name, what);
    stop_on_error();
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Sign-extended random value with the given number of bits
  function automatic logic [15:0] random_word(input int bits);
    logic signed [31:0] value;
    rng_stim = xorshift(rng_stim);
    value = $signed(rng_stim) >>> (32 - bits);
    return value[15:0];
  endfunction

  // y = sat((sum(x*w) + (b << 3)) >>> 3)
  function automatic logic [15:0] expected_output(input int row);
    longint sum;
    sum = 0;
    for (int k = 0; k < linear_pkg::IN_FEATURES; k++) begin
      sum = sum + longint'(cur_x[k]) * longint'(w_mat[row][k]);
    end
    sum = sum + longint'(b_vec[row]) * 8;
    sum = sum >>> 3;
    if (sum > 32767) begin
      return 16'h7fff;
    end else if (sum < -32768) begin
      return 16'h8000;
    end
    return sum[15:0];
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_for_drain();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
  endtask

  task automatic set_identity(input int scale);
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      for (int c = 0; c < linear_pkg::IN_FEATURES; c++) begin
        w_mat[r][c] = (r == c) ? 16'(scale) : 16'sd0;
      end
    end
  endtask

  task automatic set_bias(input int b0, input int b1, input int b2, input int b3);
    b_vec[0] = 16'(b0);
    b_vec[1] = 16'(b1);
    b_vec[2] = 16'(b2);
    b_vec[3] = 16'(b3);
  endtask

  task automatic set_input(input int x0, input int x1, input int x2, input int x3);
    cur_x[0] = 16'(x0);
    cur_x[1] = 16'(x1);
    cur_x[2] = 16'(x2);
    cur_x[3] = 16'(x3);
  endtask

  task automatic randomize_weights();
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      for (int c = 0; c < linear_pkg::IN_FEATURES; c++) begin
        w_mat[r][c] = random_word(12);
      end
      b_vec[r] = random_word(10);
    end
  endtask

  task automatic randomize_input();
    for (int k = 0; k < linear_pkg::IN_FEATURES; k++) begin
      cur_x[k] = random_word(14);
    end
  endtask

  // Row-major weights, then the biases, after a load pulse
  task automatic load_weights();
    logic [15:0] beats [linear_pkg::LOAD_BEATS];
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      for (int c = 0; c < linear_pkg::IN_FEATURES; c++) begin
        beats[r * linear_pkg::IN_FEATURES + c] = w_mat[r][c];
      end
      beats[linear_pkg::OUT_FEATURES * linear_pkg::IN_FEATURES + r] = b_vec[r];
    end
    wait_for_drain();
    load = 1'b1;
    loading = 1'b1;
    next_cycle();
    load = 1'b0;
    for (int i = 0; i < linear_pkg::LOAD_BEATS; i++) begin
      w_data = beats[i];
      w_valid = 1'b1;
      // Ready is settled here and tells whether the next edge transfers
      while (!w_ready) begin
        next_cycle();
      end
      next_cycle();
    end
    w_valid = 1'b0;
    loading = 1'b0;
    loaded = 1'b1;
  endtask

  task automatic send_vector(input bit with_gaps);
    int gap;
    for (int r = 0; r < linear_pkg::OUT_FEATURES; r++) begin
      exp_q.push_back(expected_output(r));
    end
    for (int k = 0; k < linear_pkg::IN_FEATURES; k++) begin
      if (with_gaps) begin
        rng_stim = xorshift(rng_stim);
        gap = int'(rng_stim % 3);
        repeat (gap) next_cycle();
      end
      x_data = cur_x[k];
      x_valid = 1'b1;
      while (!x_ready) begin
        next_cycle();
      end
      next_cycle();
      x_valid = 1'b0;
    end
  endtask

  initial begin : ready_driver
    logic use_random;
    y_ready = 1'b0;
    forever begin
      @(posedge clk);
      use_random = random_ready;
      #1;
      if (use_random) begin
        rng_ready = xorshift(rng_ready);
        y_ready = rng_ready[7];
      end else begin
        y_ready = 1'b1;
      end
    end
  end

  // Tracks the input element count and the edges after element 3
  always @(posedge clk) begin : input_tracker
    if (reset) begin
      x_elem <= 2'd0;
      last_x_d1 <= 1'b0;
      last_x_d2 <= 1'b0;
    end else begin
      last_x_d1 <= x_valid && x_ready && (x_elem == 2'd3);
      last_x_d2 <= last_x_d1;
      if (x_valid && x_ready) begin
        x_elem <= x_elem + 2'd1;
      end
    end
  end

  always @(posedge clk) begin : output_monitor
    logic [15:0] expected;
    if (reset) begin
      out_idx = 2'd0;
    end else if (y_valid && y_ready) begin
      if (exp_q.size() == 0) begin
        report_problem("an output arrived with no expected value");
      end else begin
        expected = exp_q.pop_front();
        a_y_data : assert (y_data == expected)
          else report_mismatch("y_data", int'($signed(expected)), int'($signed(y_data)));
        a_y_last : assert (y_last == (out_idx == 2'd3))
          else report_mismatch("y_last", int'(out_idx == 2'd3), int'(y_last));
        out_idx = out_idx + 2'd1;
      end
    end
  end

  a_reset_outputs : assert property (
    @(posedge clk) $fell(reset) |-> (!w_ready && !x_ready && !y_valid && !y_last)
  ) else report_problem("outputs were not low after reset");

  a_no_x_before_weights : assert property (
    @(posedge clk) disable iff (reset) (!loaded || loading) |-> !x_ready
  ) else report_problem("x_ready was high before or during a weight load");

  a_w_ready_in_load : assert property (
    @(posedge clk) disable iff (reset) w_ready |-> loading
  ) else report_problem("w_ready was high outside a weight load");

  a_hold_output : assert property (
    @(posedge clk) disable iff (reset)
    (y_valid && !y_ready) |=> (y_valid && $stable(y_data) && $stable(y_last))
  ) else report_problem("output changed or dropped valid under back-pressure");

  a_valid_not_early : assert property (
    @(posedge clk) disable iff (reset) (last_x_d1 || last_x_d2) |-> !y_valid
  ) else report_problem("y_valid rose too early after the last input");

  a_valid_on_time : assert property (
    @(posedge clk) disable iff (reset) last_x_d2 |=> y_valid
  ) else report_problem("y_valid did not rise 2 cycles after the last input");

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    report_problem("watchdog expired before all tests finished");
  end

  initial begin : main
    reset = 1'b1;
    load = 1'b0;
    w_data = '0;
    w_valid = 1'b0;
    x_data = '0;
    x_valid = 1'b0;
    loaded = 1'b0;
    loading = 1'b0;
    random_ready = 1'b0;
    rng_stim = SEED;
    rng_ready = xorshift(SEED);
    test_name = "reset";
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // No weights yet, so x_ready must stay low
    x_valid = 1'b1;
    repeat (8) next_cycle();
    x_valid = 1'b0;

    test_name = "identity";
    set_identity(8);
    set_bias(3, -5, 10, 0);
    load_weights();
    set_input(100, -200, 37, 5);
    send_vector(1'b0);
    set_input(-1000, 2000, 0, 77);
    send_vector(1'b0);
    wait_for_drain();

    test_name = "saturation";
    set_identity(0);
    for (int c = 0; c < linear_pkg::IN_FEATURES; c++) begin
      w_mat[0][c] = 16'sh7fff;
      w_mat[1][c] = 16'sh8000;
    end
    w_mat[2][2] = 16'sd8;
    w_mat[3][3] = -16'sd8;
    set_bias(0, 0, 0, 0);
    load_weights();
    set_input(32767, 32767, 32767, 32767);
    send_vector(1'b0);
    set_input(-32768, -32768, -32768, -32768);
    send_vector(1'b0);
    wait_for_drain();

    test_name = "backpressure";
    random_ready = 1'b1;
    randomize_weights();
    load_weights();
    repeat (3) begin
      randomize_input();
      send_vector(1'b0);
    end
    wait_for_drain();
    random_ready = 1'b0;

    test_name = "reload";
    set_identity(16);
    set_bias(0, 0, 0, 0);
    load_weights();
    set_input(50, -60, 70, -80);
    send_vector(1'b0);
    wait_for_drain();
    randomize_weights();
    load_weights();
    send_vector(1'b0);
    wait_for_drain();

    test_name = "random";
    random_ready = 1'b1;
    randomize_weights();
    load_weights();
    repeat (20) begin
      randomize_input();
      send_vector(1'b1);
    end
    wait_for_drain();
    repeat (4) next_cycle();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/linear_pkg.sv
hdl/index_if.sv
hdl/index_counter.sv
hdl/weight_store.sv
hdl/mac_array.sv
hdl/output_slice.sv
hdl/layer_controller.sv
hdl/linear_layer.sv
sim/tb_clock_gen.sv
sim/tb_linear_layer.sv
